// ==== Makefile ====
# Verilator build and run of the fm timing core testbench

VERILATOR ?= verilator
TOP       ?= fm_clk_tb
FLIST     ?= fm_clk_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/fm_clk_checker.sv ====
// ********************
// bound assertions: axi response hold, enable origin, irq source
// ********************
`timescale 1ns/1ps
`default_nettype none

module fm_clk_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 cen,
    input fm_clk_pkg::axil_b_t  b,
    input logic                 bready,
    input fm_clk_pkg::axil_r_t  r,
    input logic                 rready,
    input fm_clk_pkg::cen_bus_t cen_out,
    input logic                 irq,
    input logic                 flag_a,
    input logic                 flag_b
);
    // write response held until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        b.bvalid && !bready |=> b.bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r.rvalid && !rready |=> r.rvalid)
        else $error("rvalid dropped before rready");

    // any enable comes from a cen one edge back
    a_en_after_cen: assert property (@(posedge clk) disable iff (!rst_n)
        (cen_out != '0) |-> $past(cen))
        else $error("enable pulse without cen on the previous cycle");

    // irq is registered, so the flag shows one cycle earlier
    a_irq_flag: assert property (@(posedge clk) disable iff (!rst_n)
        irq |-> $past(flag_a || flag_b))
        else $error("irq high with no timer flag");
endmodule

bind fm_clk_top fm_clk_checker u_chk (
    .clk(clk), .rst_n(rst_n), .cen(cen),
    .b(b), .bready(bready), .r(r), .rready(rready),
    .cen_out(cen_out), .irq(irq), .flag_a(flag_a), .flag_b(flag_b)
);

`default_nettype wire

// ==== bench/fm_clk_tb.sv ====
// ********************
// directed tests of the fm timing core: axi tasks, enable counts,
// timers, back-pressure, check task and timeout
// ********************
`timescale 1ns/1ps
`default_nettype none

module fm_clk_tb;
    import fm_clk_pkg::*;

    localparam int timeout_cycles = 40000;  // ~10x the whole run

    logic        clk;
    logic        rst_n;
    logic        cen;
    axil_aw_t    aw;
    axil_w_t     w;
    axil_b_t     b;
    axil_ar_t    ar;
    axil_r_t     r;
    logic        awready, wready, arready;
    logic        bready, rready;
    cen_bus_t    cen_out;
    logic        irq;
    logic [31:0] rng;
    logic [1:0]  exp_div;   // div_sel as the commands should leave it
    int          n_cen, n_fm, n_ssg, n_div3, n_a666, n_a111, n_a55;
    int          cycle_cnt = 0;

    fm_clk_tb_clk u_clk (.clk(clk));

    fm_clk_top #(.use_ssg(1'b1), .tmr_a_w(10), .tmr_b_w(8)) u_dut (
        .clk, .rst_n, .cen, .aw, .awready, .w, .wready, .b, .bready,
        .ar, .arready, .r, .rready, .cen_out, .irq
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // status word: flags in bits 1:0, div_sel in 3:2
    function automatic logic [31:0] status_word(input logic [1:0] d, input logic fb,
                                                input logic fa);
        return {28'd0, d, fb, fa};
    endfunction

    task automatic check(input string name, input int expected, input int actual,
                         input int tol);
        if (actual > expected + tol || actual + tol < expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "check failed");
        end
    endtask

    // prescaler command semantics: set, set, clear
    task automatic model_write(input logic [7:0] addr);
        case (addr)
            addr_div_set1: exp_div[1] = 1'b1;
            addr_div_set0: exp_div[0] = 1'b1;
            addr_div_clr:  exp_div = 2'b00;
            default: ;
        endcase
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        aw     <= '{awaddr: addr, awvalid: 1'b1};
        w      <= '{wdata: data, wvalid: 1'b1};
        bready <= 1'b1;
        do @(negedge clk); while (!awready);
        check("axi_write wready", 1, int'(wready), 0);
        @(posedge clk);                         // handshake edge
        aw.awvalid <= 1'b0;
        w.wvalid   <= 1'b0;
        do @(negedge clk); while (!b.bvalid);
        check("axi_write bresp", 0, int'(b.bresp), 0);
        @(posedge clk);                         // response taken here
        bready <= 1'b0;
        model_write(addr);
    endtask

    task automatic axi_read(input logic [31:0] expected, input string name);
        @(posedge clk);
        ar     <= '{araddr: 8'h00, arvalid: 1'b1};   // any address gives status
        rready <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        ar.arvalid <= 1'b0;
        do @(negedge clk); while (!r.rvalid);
        check(name, int'(expected), int'(r.rdata), 0);
        check({name, " rresp"}, 0, int'(r.rresp), 0);
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // counts enables over a window of n cen pulses, sampled mid-cycle
    task automatic count_window(input int n);
        n_cen = 0;
        n_fm = 0;
        n_ssg = 0;
        n_div3 = 0;
        n_a666 = 0;
        n_a111 = 0;
        n_a55 = 0;
        while (n_cen < n) begin
            @(negedge clk);
            if (cen) n_cen++;
            if (cen_out.fm) n_fm++;
            if (cen_out.ssg) n_ssg++;
            if (cen_out.div3) n_div3++;
            if (cen_out.a666) n_a666++;
            if (cen_out.a111) n_a111++;
            if (cen_out.a55) n_a55++;
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check("reset: irq", 0, int'(irq), 0);
        axi_read(status_word(2'b10, 1'b0, 1'b0), "reset: status");
        count_window(720);
        check("reset: fm count", 120, n_fm, 1);
        check("reset: ssg count", 180, n_ssg, 1);
        check("reset: div3 count", 240, n_div3, 1);
        check("reset: a666 count", 60, n_a666, 1);
        check("reset: a111 count", 10, n_a111, 1);
        check("reset: a55 count", 5, n_a55, 1);
    endtask

    task automatic test_prescaler();
        axi_write(addr_div_set0, 32'd0);        // 10 -> 11
        count_window(720);
        check("prescaler 11: fm count", 240, n_fm, 1);
        check("prescaler 11: ssg count", 360, n_ssg, 1);
        axi_write(addr_div_clr, 32'd0);         // -> 00
        count_window(720);
        check("prescaler 00: fm count", 360, n_fm, 1);
        check("prescaler 00: ssg count", 720, n_ssg, 1);
        axi_write(addr_div_set1, 32'd0);        // -> 10
        axi_read(status_word(exp_div, 1'b0, 1'b0), "prescaler: status after 0x2D");
    endtask

    task automatic test_timer_a();
        int n;
        axi_write(addr_tmr_a, 32'd1020);        // overflow every 4 ticks
        axi_write(addr_tmr_ctl, 32'h05);        // run a, irq enable a
        n = 0;
        while (n < 4) begin
            @(negedge clk);
            if (cen_out.fm) n++;
        end
        repeat (3) @(negedge clk);              // flag, then registered irq
        check("timer_a: irq set", 1, int'(irq), 0);
        axi_read(status_word(exp_div, 1'b0, 1'b1), "timer_a: flag_a set");
        axi_write(addr_tmr_ctl, 32'h14);        // stop a, clear flag a, keep irq en
        repeat (3) @(negedge clk);
        check("timer_a: irq cleared", 0, int'(irq), 0);
        axi_read(status_word(exp_div, 1'b0, 1'b0), "timer_a: flag_a cleared");
    endtask

    task automatic test_timer_b();
        int n;
        axi_write(addr_tmr_b, 32'd254);         // overflow every 2 ticks
        axi_write(addr_tmr_ctl, 32'h02);        // run b, no irq enable
        n = 0;
        while (n < 2) begin
            @(negedge clk);
            if (cen_out.a111) n++;
        end
        repeat (3) @(negedge clk);
        check("timer_b: irq low", 0, int'(irq), 0);
        axi_read(status_word(exp_div, 1'b1, 1'b0), "timer_b: flag_b set");
    endtask

    task automatic test_backpressure();
        @(posedge clk);
        aw     <= '{awaddr: addr_div_set0, awvalid: 1'b1};
        w      <= '{wdata: 32'd0, wvalid: 1'b1};
        bready <= 1'b0;
        do @(negedge clk); while (!awready);
        @(posedge clk);                         // first write taken
        aw <= '{awaddr: addr_div_clr, awvalid: 1'b1};   // second one waits
        model_write(addr_div_set0);
        do @(negedge clk); while (!b.bvalid);
        repeat (5) begin
            @(negedge clk);
            check("backpressure: bvalid held", 1, int'(b.bvalid), 0);
            check("backpressure: second write blocked", 0, int'(awready), 0);
        end
        @(posedge clk);
        bready <= 1'b1;
        do @(negedge clk); while (!awready);
        @(posedge clk);
        aw.awvalid <= 1'b0;
        w.wvalid   <= 1'b0;
        model_write(addr_div_clr);
        do @(negedge clk); while (!b.bvalid);
        @(posedge clk);
        bready <= 1'b0;
        axi_read(status_word(exp_div, 1'b1, 1'b0), "backpressure: status");
    endtask

    // cen source, about half the cycles
    initial begin
        rng = 32'h739f;
        cen = 1'b0;
        forever begin
            @(posedge clk);
            rng = lcg_next(rng);
            cen <= rng[16];
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", timeout_cycles);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_n   = 1'b0;
        aw      = '0;
        w       = '0;
        ar      = '0;
        bready  = 1'b0;
        rready  = 1'b0;
        exp_div = 2'b10;    // reset setting
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_prescaler();
        test_timer_a();
        test_timer_b();
        test_backpressure();
        $display("PASS: all tests");
        $finish;
    end
endmodule

`default_nettype wire

// ==== bench/fm_clk_tb_clk.sv ====
// ********************
// testbench clock, 40 ns period
// ********************
`timescale 1ns/1ps
`default_nettype none

module fm_clk_tb_clk #(
    parameter int half_ns = 20  // half period
) (
    output logic clk
);
    initial clk = 1'b0;
    always #(half_ns) clk = ~clk;
endmodule

`default_nettype wire

// ==== common/fm_clk_pkg.sv ====
// ********************
// shared types and constants of the fm timing core
// addresses, divider setting, enable bundle, axi4-lite channels
// ********************
`default_nettype none

package fm_clk_pkg;

    // prescaler setting, bit 1 from 0x2D, bit 0 from 0x2E
    typedef logic [1:0] div_sel_t;
    localparam div_sel_t div_sel_rst = 2'b10;    // FM 1/6, SSG 1/4

    // one-cycle clock enables out of the divider
    typedef struct packed {
        logic fm;       // fm operator rate
        logic div3;
        logic ssg;
        logic a666;     // adpcm-a 666 kHz
        logic a111;
        logic a55;
    } cen_bus_t;

    typedef struct packed {logic [7:0] awaddr; logic awvalid;} axil_aw_t;
    typedef struct packed {logic [31:0] wdata; logic wvalid;} axil_w_t;
    typedef struct packed {logic bvalid; logic [1:0] bresp;} axil_b_t;
    typedef struct packed {logic [7:0] araddr; logic arvalid;} axil_ar_t;
    typedef struct packed {logic rvalid; logic [31:0] rdata; logic [1:0] rresp;} axil_r_t;

    localparam logic [1:0] resp_okay = 2'b00;

    // register map, same numbers as the chip's own
    localparam logic [7:0] addr_div_set1 = 8'h2D;
    localparam logic [7:0] addr_div_set0 = 8'h2E;
    localparam logic [7:0] addr_div_clr  = 8'h2F;
    localparam logic [7:0] addr_tmr_a    = 8'h24;
    localparam logic [7:0] addr_tmr_b    = 8'h26;
    localparam logic [7:0] addr_tmr_ctl  = 8'h27;

    // fixed moduli of the adpcm chain and the /3 enable
    localparam logic [4:0] a666_mod = 5'd12;
    localparam logic [4:0] a111_mod = 5'd6;     // counted on a666 wraps
    localparam logic [4:0] a55_mod  = 5'd2;     // counted on a111 wraps
    localparam logic [4:0] div3_mod = 5'd3;

endpackage

`default_nettype wire

// ==== fm_clk_top.f ====
common/fm_clk_pkg.sv
src/fm_timer.sv
src/fm_cen_div.sv
fm_regs/fm_regs.sv
src/fm_clk_top.sv
bench/fm_clk_checker.sv
bench/fm_clk_tb_clk.sv
bench/fm_clk_tb.sv

// ==== fm_regs/fm_regs.sv ====
// ********************
// axi4-lite register port: prescaler commands, timer loads,
// timer control, status read and registered irq
// ********************
`timescale 1ns/1ps
`default_nettype none

module fm_regs #(
    parameter int tmr_a_w = 10,
    parameter int tmr_b_w = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fm_clk_pkg::axil_aw_t aw,
    output logic                 awready,
    input  fm_clk_pkg::axil_w_t  w,
    output logic                 wready,
    output fm_clk_pkg::axil_b_t  b,
    input  logic                 bready,
    input  fm_clk_pkg::axil_ar_t ar,
    output logic                 arready,
    output fm_clk_pkg::axil_r_t  r,
    input  logic                 rready,
    output fm_clk_pkg::div_sel_t div_sel,
    output logic [tmr_a_w-1:0]   tmr_a_load,
    output logic [tmr_b_w-1:0]   tmr_b_load,
    output logic                 run_a,
    output logic                 run_b,
    output logic                 clr_a,
    output logic                 clr_b,
    input  logic                 flag_a,
    input  logic                 flag_b,
    output logic                 irq
);
    import fm_clk_pkg::*;

    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        irq_en_a;
    logic        irq_en_b;
    logic        wr_en;     // write handshake completes this edge
    logic        rd_en;
    logic [31:0] status;

    assign wr_en  = awready & aw.awvalid & w.wvalid;
    assign rd_en  = arready & ar.arvalid;
    assign status = {28'd0, div_sel, flag_b, flag_a};

    assign wready = awready;    // aw and w always taken together
    assign b = '{bvalid: bvalid_q, bresp: resp_okay};
    assign r = '{rvalid: rvalid_q, rdata: rdata_q, rresp: resp_okay};

    // handshake state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            bvalid_q <= 1'b0;
            arready  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            // one-cycle ready pulse, never while a response waits
            awready <= aw.awvalid & w.wvalid & ~awready & ~bvalid_q;
            arready <= ar.arvalid & ~arready & ~rvalid_q;
            if (wr_en)
                bvalid_q <= 1'b1;
            else if (bready)
                bvalid_q <= 1'b0;
            if (rd_en)
                rvalid_q <= 1'b1;
            else if (rready)
                rvalid_q <= 1'b0;
        end
    end

    // read data, status sampled at the address handshake
    always_ff @(posedge clk) begin
        if (rd_en)
            rdata_q <= status;
    end

    // register writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_sel    <= div_sel_rst;
            tmr_a_load <= '0;
            tmr_b_load <= '0;
            run_a      <= 1'b0;
            run_b      <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_a      <= 1'b0;
            clr_b      <= 1'b0;
        end else begin
            clr_a <= 1'b0;  // one-shot
            clr_b <= 1'b0;
            if (wr_en) begin
                case (aw.awaddr)
                    addr_div_set1: div_sel[1] <= 1'b1;
                    addr_div_set0: div_sel[0] <= 1'b1;
                    addr_div_clr:  div_sel    <= 2'b00;
                    addr_tmr_a:    tmr_a_load <= w.wdata[tmr_a_w-1:0];
                    addr_tmr_b:    tmr_b_load <= w.wdata[tmr_b_w-1:0];
                    addr_tmr_ctl: begin
                        run_a    <= w.wdata[0];
                        run_b    <= w.wdata[1];
                        irq_en_a <= w.wdata[2];
                        irq_en_b <= w.wdata[3];
                        clr_a    <= w.wdata[4];
                        clr_b    <= w.wdata[5];
                    end
                    default: ;  // unmapped, still answered
                endcase
            end
        end
    end

    // irq out of the flags and their enables
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            irq <= 1'b0;
        else
            irq <= (flag_a & irq_en_a) | (flag_b & irq_en_b);
    end

endmodule

`default_nettype wire

// ==== src/fm_cen_div.sv ====
// ********************
// clock-enable divider: fm, ssg, /3 and adpcm-a enables from cen
// ********************
`timescale 1ns/1ps
`default_nettype none

module fm_cen_div #(
    parameter bit use_ssg = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  fm_clk_pkg::div_sel_t div_sel,
    output fm_clk_pkg::cen_bus_t cen_out
);
    import fm_clk_pkg::*;

    logic [3:0] fm_pres;    // terminal count, ratio minus one
    logic [2:0] ssg_pres;
    logic [3:0] fm_cnt;
    logic [2:0] ssg_cnt;
    logic [4:0] div3_cnt;
    logic [4:0] a666_cnt;
    logic [4:0] a111_cnt;
    logic [4:0] a55_cnt;
    logic       z666;
    logic       z111;
    logic       z55;

    // ratios per div_sel, as in the chip datasheet
    always_comb begin
        case (div_sel)
            2'b10: begin    // reset value, FM 1/6 SSG 1/4
                fm_pres  = 4'd5;
                ssg_pres = 3'd3;
            end
            2'b11: begin    // FM 1/3 SSG 1/2
                fm_pres  = 4'd2;
                ssg_pres = 3'd1;
            end
            default: begin  // 0x, FM 1/2 SSG 1/1
                fm_pres  = 4'd1;
                ssg_pres = 3'd0;
            end
        endcase
    end

    assign z666 = (a666_cnt == 5'd0);
    assign z111 = (a111_cnt == 5'd0);
    assign z55  = (a55_cnt == 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_cnt   <= '0;
            ssg_cnt  <= '0;
            div3_cnt <= '0;
            a666_cnt <= '0;
            a111_cnt <= '0;
            a55_cnt  <= '0;
        end else if (cen) begin
            // >= so a smaller ratio written mid-count wraps at once
            fm_cnt   <= (fm_cnt >= fm_pres) ? 4'd0 : fm_cnt + 4'd1;
            ssg_cnt  <= (ssg_cnt >= ssg_pres) ? 3'd0 : ssg_cnt + 3'd1;
            div3_cnt <= (div3_cnt == div3_mod - 5'd1) ? 5'd0 : div3_cnt + 5'd1;
            a666_cnt <= (a666_cnt == a666_mod - 5'd1) ? 5'd0 : a666_cnt + 5'd1;
            if (z666) begin     // chain steps on the 666k pulse
                a111_cnt <= (a111_cnt == a111_mod - 5'd1) ? 5'd0 : a111_cnt + 5'd1;
                if (z111)
                    a55_cnt <= (a55_cnt == a55_mod - 5'd1) ? 5'd0 : a55_cnt + 5'd1;
            end
        end
    end

    // registered enables, one clk wide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_out <= '0;
        end else begin
            cen_out.fm   <= cen & (fm_cnt == 4'd0);
            cen_out.ssg  <= use_ssg & cen & (ssg_cnt == 3'd0);
            cen_out.div3 <= cen & (div3_cnt == 5'd0);
            cen_out.a666 <= cen & z666;
            cen_out.a111 <= cen & z666 & z111;
            cen_out.a55  <= cen & z666 & z111 & z55;
        end
    end

endmodule

`default_nettype wire

// ==== src/fm_clk_top.sv ====
// ********************
// fm timing core top: registers, divider, timers a and b
// ********************
`timescale 1ns/1ps
`default_nettype none

module fm_clk_top #(
    parameter bit use_ssg = 1'b1,
    parameter int tmr_a_w = 10,
    parameter int tmr_b_w = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  fm_clk_pkg::axil_aw_t aw,
    output logic                 awready,
    input  fm_clk_pkg::axil_w_t  w,
    output logic                 wready,
    output fm_clk_pkg::axil_b_t  b,
    input  logic                 bready,
    input  fm_clk_pkg::axil_ar_t ar,
    output logic                 arready,
    output fm_clk_pkg::axil_r_t  r,
    input  logic                 rready,
    output fm_clk_pkg::cen_bus_t cen_out,
    output logic                 irq
);
    import fm_clk_pkg::*;

    div_sel_t           div_sel;
    logic [tmr_a_w-1:0] tmr_a_load;
    logic [tmr_b_w-1:0] tmr_b_load;
    logic               run_a, run_b;
    logic               clr_a, clr_b;
    logic               flag_a, flag_b;

    fm_regs #(.tmr_a_w(tmr_a_w), .tmr_b_w(tmr_b_w)) u_regs (
        .clk, .rst_n,
        .aw, .awready, .w, .wready, .b, .bready,
        .ar, .arready, .r, .rready,
        .div_sel, .tmr_a_load, .tmr_b_load,
        .run_a, .run_b, .clr_a, .clr_b,
        .flag_a, .flag_b, .irq
    );

    fm_cen_div #(.use_ssg(use_ssg)) u_div (
        .clk, .rst_n, .cen, .div_sel, .cen_out
    );

    // timer A on the fm rate
    fm_timer #(.width(tmr_a_w)) u_tmr_a (
        .clk, .rst_n, .tick(cen_out.fm), .run(run_a),
        .clr_flag(clr_a), .load(tmr_a_load), .flag(flag_a)
    );

    // timer B on the 111 kHz adpcm rate
    fm_timer #(.width(tmr_b_w)) u_tmr_b (
        .clk, .rst_n, .tick(cen_out.a111), .run(run_b),
        .clr_flag(clr_b), .load(tmr_b_load), .flag(flag_b)
    );

endmodule

`default_nettype wire

// ==== src/fm_timer.sv ====
// ********************
// load, count and overflow timer with sticky flag
// ********************
`timescale 1ns/1ps
`default_nettype none

module fm_timer #(
    parameter int width = 10
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,      // counting enable from the divider
    input  logic             run,
    input  logic             clr_flag,
    input  logic [width-1:0] load,
    output logic             flag
);

    logic [width-1:0] cnt;
    logic             run_q;
    logic             start;    // run rising edge
    logic             wrap;

    assign start = run & ~run_q;
    assign wrap  = run & tick & (&cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            cnt   <= '0;
        end else begin
            run_q <= run;
            if (start)
                cnt <= load;
            else if (wrap)
                cnt <= load;    // reload, period is 2^width - load
            else if (run && tick)
                cnt <= cnt + 1'b1;
        end
    end

    // overflow flag, held until cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flag <= 1'b0;
        else if (wrap && !start)
            flag <= 1'b1;       // new overflow beats a clear
        else if (clr_flag)
            flag <= 1'b0;
    end

endmodule

`default_nettype wire
